// File: verilog/lsu_params.svh
/* Load/store unit sizing
   Data width, bus word address width, segment shift and lane count */

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`default_nettype none

// Register and bus data width
`define LSU_DATA_W 16

// Word address on the bus, byte address bits 19 down to 1
`define LSU_ADDR_W 19

// Segment lands 4 bits up in the byte address, so 3 in the word address
`define LSU_SEG_SHIFT 3

// Byte lanes on the data bus
`define LSU_LANES 2

`default_nettype wire

`endif

// File: verilog/lsu_state_pkg.sv
/* Sequencer state encoding for the load/store unit */

`default_nettype none

package lsu_state_pkg;

  // ==================================================
  // Bus sequencer states
  // ==================================================
  // BEAT states are the first cycle of a beat, WAIT states hold it
  // until the acknowledge arrives
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_BEAT1 = 3'd1,
    ST_WAIT1 = 3'd2,
    // Bus released for one cycle between the two halves of a split word
    ST_GAP   = 3'd3,
    ST_BEAT2 = 3'd4,
    ST_WAIT2 = 3'd5
  } lsu_state_t;

endpackage

`default_nettype wire

// File: verilog/lsu_bus_pkg.sv
/* Bus beat kinds and byte lane masks shared by the sequencer and data path */

`include "lsu_params.svh"

`default_nettype none

package lsu_bus_pkg;

  // ==================================================
  // Beat kind issued to the data path
  // ==================================================
  typedef enum logic [2:0] {
    OP_NONE         = 3'd0,
    OP_WORD         = 3'd1,
    OP_BYTE_EVEN    = 3'd2,
    OP_BYTE_ODD     = 3'd3,
    // Odd word access, low byte first on the high lane
    OP_SPLIT_FIRST  = 3'd4,
    // Then high byte on the low lane of the next word
    OP_SPLIT_SECOND = 3'd5
  } bus_op_t;

  // Lane mask, bit 1 is the high lane
  typedef logic [`LSU_LANES-1:0] lane_sel_t;

  localparam lane_sel_t LANE_NONE = 2'b00;
  localparam lane_sel_t LANE_LO   = 2'b01;
  localparam lane_sel_t LANE_HI   = 2'b10;
  localparam lane_sel_t LANE_BOTH = 2'b11;

endpackage

`default_nettype wire

// File: verilog/lsu_sequencer.sv
/* Load/store sequencer
   Orders one or two bus beats per request and flags completion */

`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_read,
  input  logic                 mem_write,
  input  logic                 is_8bit,
  input  logic                 odd_offset,
  input  logic                 m_ack,
  output logic                 busy,
  output logic                 m_access,
  output logic                 m_wr_en,
  output logic                 start,
  output logic                 advance,
  output logic                 finish,
  output logic                 capture,
  output lsu_bus_pkg::bus_op_t beat_op
);
  import lsu_state_pkg::*;
  import lsu_bus_pkg::*;

  lsu_state_t state;
  logic       complete;
  logic       write_q;
  logic       byte_q;
  logic       request;
  logic       split;
  logic       ack_beat1;
  logic       ack_beat2;
  bus_op_t    first_op;

  // Kind of the first beat from width and offset parity
  function automatic bus_op_t first_beat_op(input logic is_byte, input logic odd);
    if (is_byte) begin
      return odd ? OP_BYTE_ODD : OP_BYTE_EVEN;
    end
    return odd ? OP_SPLIT_FIRST : OP_WORD;
  endfunction

  // ==================================================
  // Handshake decode
  // ==================================================
  assign request  = mem_read | mem_write;
  // Complete masks the still-held request for one cycle
  assign busy     = request & ~complete;
  assign m_access = (state == ST_BEAT1) || (state == ST_WAIT1) ||
                    (state == ST_BEAT2) || (state == ST_WAIT2);
  assign m_wr_en  = m_access & write_q;

  // Only a word at an odd offset needs two beats
  assign split    = ~byte_q & odd_offset;
  assign first_op = first_beat_op(byte_q, odd_offset);

  assign start     = (state == ST_IDLE) & request & ~complete;
  assign ack_beat1 = ((state == ST_BEAT1) || (state == ST_WAIT1)) & m_ack;
  assign ack_beat2 = ((state == ST_BEAT2) || (state == ST_WAIT2)) & m_ack;
  assign advance   = ack_beat1 & split;
  assign finish    = (ack_beat1 & ~split) | ack_beat2;
  assign capture   = (ack_beat1 | ack_beat2) & ~write_q;

  // Beat kind for the bus registers in the next cycle
  always_comb begin
    case (state)
      ST_IDLE: beat_op = start ? first_beat_op(is_8bit, odd_offset) : OP_NONE;
      ST_BEAT1, ST_WAIT1: begin
        if (!m_ack) begin
          beat_op = first_op;
        end else if (split) begin
          beat_op = OP_SPLIT_SECOND;
        end else begin
          beat_op = OP_NONE;
        end
      end
      ST_GAP: beat_op = OP_SPLIT_SECOND;
      ST_BEAT2, ST_WAIT2: beat_op = m_ack ? OP_NONE : OP_SPLIT_SECOND;
      default: beat_op = OP_NONE;
    endcase
  end

  // ==================================================
  // State register
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      complete <= 1'b0;
      write_q  <= 1'b0;
      byte_q   <= 1'b0;
    end else begin
      // One-cycle pulse after the last acknowledge
      complete <= finish;
      case (state)
        ST_IDLE: begin
          if (start) begin
            // Read wins if both are raised
            write_q <= mem_write & ~mem_read;
            byte_q  <= is_8bit;
            state   <= ST_BEAT1;
          end
        end
        ST_BEAT1, ST_WAIT1: begin
          if (m_ack) begin
            state <= split ? ST_GAP : ST_IDLE;
          end else begin
            state <= ST_WAIT1;
          end
        end
        ST_GAP: state <= ST_BEAT2;
        ST_BEAT2, ST_WAIT2: state <= m_ack ? ST_IDLE : ST_WAIT2;
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/lsu_address.sv
/* Load/store address path
   MAR, segment plus offset pre-computation and the bus address register */

`include "lsu_params.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_address (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write_mar,
  input  logic                   start,
  input  logic                   advance,
  input  logic                   finish,
  input  logic [`LSU_DATA_W-1:0] segment,
  input  logic [`LSU_DATA_W-1:0] mar_in,
  output logic [`LSU_DATA_W-1:0] mar_out,
  output logic                   odd_offset,
  output logic [`LSU_ADDR_W-1:0] m_addr
);
  localparam int DATA_W = `LSU_DATA_W;
  localparam int ADDR_W = `LSU_ADDR_W;

  logic [DATA_W-1:0] mar;
  logic [ADDR_W-1:0] phys_addr;

  // MAR and word address, the add stays off the bus path
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mar       <= '0;
      phys_addr <= '0;
    end else if (write_mar) begin
      mar       <= mar_in;
      phys_addr <= (ADDR_W'(segment) << `LSU_SEG_SHIFT) + ADDR_W'(mar_in[DATA_W-1:1]);
    end
  end

  // Bus address, steps once for the second half of a split word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      m_addr <= '0;
    end else if (start) begin
      m_addr <= phys_addr;
    end else if (advance) begin
      m_addr <= m_addr + ADDR_W'(1);
    end else if (finish) begin
      m_addr <= '0;
    end
  end

  assign mar_out    = mar;
  assign odd_offset = mar[0];

endmodule

`default_nettype wire

// File: verilog/lsu_data.sv
/* Load/store data path
   MDR, write lane steering, byte selects and read data merge */

`include "lsu_params.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_data (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write_mdr,
  input  logic [`LSU_DATA_W-1:0] mdr_in,
  input  logic [`LSU_DATA_W-1:0] m_data_in,
  input  lsu_bus_pkg::bus_op_t   beat_op,
  input  logic                   capture,
  output logic [`LSU_DATA_W-1:0] mdr_out,
  output logic [`LSU_DATA_W-1:0] m_data_out,
  output lsu_bus_pkg::lane_sel_t m_bytesel
);
  import lsu_bus_pkg::*;

  localparam int DATA_W = `LSU_DATA_W;
  localparam int BYTE_W = DATA_W / `LSU_LANES;

  logic [DATA_W-1:0] mdr;
  logic [DATA_W-1:0] wdata_next;
  lane_sel_t         sel_next;
  // Kind of the beat now on the bus, picks the merge on capture
  bus_op_t           cur_op;

  // ==================================================
  // Write lane steering
  // ==================================================
  always_comb begin
    case (beat_op)
      OP_WORD: begin
        sel_next   = LANE_BOTH;
        wdata_next = mdr;
      end
      OP_BYTE_EVEN: begin
        sel_next   = LANE_LO;
        wdata_next = {{BYTE_W{1'b0}}, mdr[BYTE_W-1:0]};
      end
      OP_BYTE_ODD, OP_SPLIT_FIRST: begin
        sel_next   = LANE_HI;
        wdata_next = {mdr[BYTE_W-1:0], {BYTE_W{1'b0}}};
      end
      OP_SPLIT_SECOND: begin
        sel_next   = LANE_LO;
        wdata_next = {{BYTE_W{1'b0}}, mdr[DATA_W-1:BYTE_W]};
      end
      default: begin
        sel_next   = LANE_NONE;
        wdata_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cur_op     <= OP_NONE;
      m_data_out <= '0;
      m_bytesel  <= LANE_NONE;
    end else begin
      cur_op     <= beat_op;
      m_data_out <= wdata_next;
      m_bytesel  <= sel_next;
    end
  end

  // ==================================================
  // MDR with read merge
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mdr <= '0;
    end else if (capture) begin
      case (cur_op)
        OP_WORD:         mdr <= m_data_in;
        OP_BYTE_EVEN:    mdr <= {{BYTE_W{1'b0}}, m_data_in[BYTE_W-1:0]};
        OP_BYTE_ODD:     mdr <= {{BYTE_W{1'b0}}, m_data_in[DATA_W-1:BYTE_W]};
        OP_SPLIT_FIRST:  mdr[BYTE_W-1:0] <= m_data_in[DATA_W-1:BYTE_W];
        OP_SPLIT_SECOND: mdr[DATA_W-1:BYTE_W] <= m_data_in[BYTE_W-1:0];
        default:         mdr <= mdr;
      endcase
    end else if (write_mdr) begin
      mdr <= mdr_in;
    end
  end

  assign mdr_out = mdr;

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
/* Load/store unit top level
   Joins the sequencer, address path and data path */

`include "lsu_params.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                   clk,
  input  logic                   reset,
  // Microcode side
  input  logic                   write_mar,
  input  logic [`LSU_DATA_W-1:0] segment,
  input  logic [`LSU_DATA_W-1:0] mar_in,
  output logic [`LSU_DATA_W-1:0] mar_out,
  input  logic                   write_mdr,
  input  logic [`LSU_DATA_W-1:0] mdr_in,
  output logic [`LSU_DATA_W-1:0] mdr_out,
  input  logic                   mem_read,
  input  logic                   mem_write,
  input  logic                   is_8bit,
  output logic                   busy,
  // Memory bus
  output logic [`LSU_ADDR_W-1:0] m_addr,
  output logic [`LSU_DATA_W-1:0] m_data_out,
  output logic                   m_access,
  output logic                   m_wr_en,
  output lsu_bus_pkg::lane_sel_t m_bytesel,
  input  logic [`LSU_DATA_W-1:0] m_data_in,
  input  logic                   m_ack
);
  import lsu_bus_pkg::*;

  logic    start;
  logic    advance;
  logic    finish;
  logic    capture;
  logic    odd_offset;
  bus_op_t beat_op;

  lsu_sequencer seq0 (
    .clk        (clk),
    .reset      (reset),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .is_8bit    (is_8bit),
    .odd_offset (odd_offset),
    .m_ack      (m_ack),
    .busy       (busy),
    .m_access   (m_access),
    .m_wr_en    (m_wr_en),
    .start      (start),
    .advance    (advance),
    .finish     (finish),
    .capture    (capture),
    .beat_op    (beat_op)
  );

  lsu_address addr0 (
    .clk        (clk),
    .reset      (reset),
    .write_mar  (write_mar),
    .start      (start),
    .advance    (advance),
    .finish     (finish),
    .segment    (segment),
    .mar_in     (mar_in),
    .mar_out    (mar_out),
    .odd_offset (odd_offset),
    .m_addr     (m_addr)
  );

  lsu_data data0 (
    .clk        (clk),
    .reset      (reset),
    .write_mdr  (write_mdr),
    .mdr_in     (mdr_in),
    .m_data_in  (m_data_in),
    .beat_op    (beat_op),
    .capture    (capture),
    .mdr_out    (mdr_out),
    .m_data_out (m_data_out),
    .m_bytesel  (m_bytesel)
  );

endmodule

`default_nettype wire

// File: bench/lsu_props.sv
/* Load/store unit bus protocol checks
   Bound into the top level, watches beat stability and the split gap */

`include "lsu_params.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_props (
  input logic                   clk,
  input logic                   reset,
  input logic                   m_access,
  input logic                   m_ack,
  input logic                   m_wr_en,
  input logic                   busy,
  input logic                   advance,
  input logic                   finish,
  input logic [`LSU_ADDR_W-1:0] m_addr,
  input logic [`LSU_DATA_W-1:0] m_data_out,
  input lsu_bus_pkg::lane_sel_t m_bytesel
);
  // Failed assertions, read back by the testbench at the end of the run
  int fail_count = 0;

  // ==================================================
  // Beat stability
  // ==================================================
  // A beat without acknowledge holds every bus output
  hold_a: assert property (@(posedge clk) disable iff (reset)
    $past(m_access && !m_ack) |-> m_access && $stable(m_addr) && $stable(m_data_out) &&
      $stable(m_wr_en) && $stable(m_bytesel))
  else begin
    $error("bus outputs moved while a beat waited for its acknowledge");
    fail_count++;
  end

  // Requester stays stalled for the whole access
  busy_a: assert property (@(posedge clk) disable iff (reset) m_access |-> busy)
  else begin
    $error("busy was low during a bus beat");
    fail_count++;
  end

  // ==================================================
  // Split gap and completion
  // ==================================================
  // One idle cycle, then the second beat one word up
  gap_a: assert property (@(posedge clk) disable iff (reset)
    $past(advance, 2) |-> m_access && !$past(m_access) && m_addr == $past(m_addr, 2) + 19'd1)
  else begin
    $error("split word gap was not a single cycle on the next word");
    fail_count++;
  end

  // Bus returns to rest after the last acknowledge
  done_a: assert property (@(posedge clk) disable iff (reset)
    $past(finish) |-> !busy && !m_access && m_addr == '0 && m_data_out == '0 &&
      m_bytesel == '0)
  else begin
    $error("bus did not return to rest after the last beat");
    fail_count++;
  end

endmodule

bind lsu_top lsu_props props0 (
  .clk        (clk),
  .reset      (reset),
  .m_access   (m_access),
  .m_ack      (m_ack),
  .m_wr_en    (m_wr_en),
  .busy       (busy),
  .advance    (advance),
  .finish     (finish),
  .m_addr     (m_addr),
  .m_data_out (m_data_out),
  .m_bytesel  (m_bytesel)
);

`default_nettype wire

// File: bench/lsu_tb.sv
/* Load/store unit testbench
   Memory model with random acknowledge delay, directed and random accesses */

`include "lsu_params.svh"

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
  localparam int SEED         = 32'h2ea2ab52;
  localparam int NUM_ACCESSES = 40;
  // Worst beat is 5 wait cycles plus issue, ack, gap and handshake
  localparam int BEAT_CYCLES  = 12;
  // Twice the worst case of two beats per access plus reset and setup
  localparam int TIMEOUT_CYCLES = 2 * NUM_ACCESSES * 2 * BEAT_CYCLES + 80;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   write_mar;
  logic [`LSU_DATA_W-1:0] segment;
  logic [`LSU_DATA_W-1:0] mar_in;
  logic [`LSU_DATA_W-1:0] mar_out;
  logic                   write_mdr;
  logic [`LSU_DATA_W-1:0] mdr_in;
  logic [`LSU_DATA_W-1:0] mdr_out;
  logic                   mem_read;
  logic                   mem_write;
  logic                   is_8bit;
  logic                   busy;
  logic [`LSU_ADDR_W-1:0] m_addr;
  logic [`LSU_DATA_W-1:0] m_data_out;
  logic                   m_access;
  logic                   m_wr_en;
  lsu_bus_pkg::lane_sel_t m_bytesel;
  logic [`LSU_DATA_W-1:0] m_data_in = '0;
  logic                   m_ack = 1'b0;

  // Sparse bus word memory and byte reference
  logic [15:0] mem [int];
  logic [7:0]  ref_mem [int];
  // Beats seen by the memory model, in order
  logic [18:0] obs_addr_q [$];
  logic [1:0]  obs_sel_q [$];
  logic        obs_wr_q [$];
  logic [15:0] obs_data_q [$];
  int          ack_delay [64];
  int          beat_idx = 0;
  int          wait_cnt = 0;
  logic        in_beat = 1'b0;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          cycles;

  always #2 clk = ~clk;

  lsu_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .write_mar  (write_mar),
    .segment    (segment),
    .mar_in     (mar_in),
    .mar_out    (mar_out),
    .write_mdr  (write_mdr),
    .mdr_in     (mdr_in),
    .mdr_out    (mdr_out),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .is_8bit    (is_8bit),
    .busy       (busy),
    .m_addr     (m_addr),
    .m_data_out (m_data_out),
    .m_access   (m_access),
    .m_wr_en    (m_wr_en),
    .m_bytesel  (m_bytesel),
    .m_data_in  (m_data_in),
    .m_ack      (m_ack)
  );

  // ==================================================
  // Memory contents and checks
  // ==================================================
  // Every address bit feeds the value of an untouched word
  function automatic logic [15:0] fill_word(input logic [18:0] waddr);
    return waddr[15:0] ^ {waddr[2:0], 13'h0} ^ {13'h0, waddr[18:16]} ^ 16'h6b1d;
  endfunction

  function automatic logic [15:0] word_at(input logic [18:0] waddr);
    return mem.exists(int'(waddr)) ? mem[int'(waddr)] : fill_word(waddr);
  endfunction

  // Reference view by physical byte address with the low byte at even addresses
  function automatic logic [7:0] byte_at(input logic [19:0] ba);
    logic [15:0] word;
    if (ref_mem.exists(int'(ba))) begin
      return ref_mem[int'(ba)];
    end
    word = fill_word(ba[19:1]);
    return ba[0] ? word[15:8] : word[7:0];
  endfunction

  function automatic int check_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
    int bad;
    bad = 0;
    assert (got == exp) else begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      bad = 1;
    end
    return bad;
  endfunction

  function automatic logic beat_count_ok(input int first, input int want);
    assert (obs_addr_q.size() == first + want) else begin
      $display("Wrong number of bus beats: saw %0d where %0d were due",
               obs_addr_q.size() - first, want);
      errors++;
    end
    return obs_addr_q.size() == first + want;
  endfunction

  task automatic check_beat(input int idx, input logic [18:0] a, input logic [1:0] sel,
                            input logic wr, input logic [15:0] d);
    errors += check_value("m_addr", 32'(obs_addr_q[idx]), 32'(a));
    errors += check_value("m_bytesel", 32'(obs_sel_q[idx]), 32'(sel));
    errors += check_value("m_wr_en", 32'(obs_wr_q[idx]), 32'(wr));
    // Write data only matters when the memory takes it
    if (wr) begin
      errors += check_value("m_data_out", 32'(obs_data_q[idx]), 32'(d));
    end
  endtask

  // Log the beat and act on it while the bus outputs are stable
  task automatic serve_beat;
    logic [15:0] word;
    obs_addr_q.push_back(m_addr);
    obs_sel_q.push_back(m_bytesel);
    obs_wr_q.push_back(m_wr_en);
    obs_data_q.push_back(m_data_out);
    word = word_at(m_addr);
    if (m_wr_en) begin
      if (m_bytesel[0]) begin
        word[7:0] = m_data_out[7:0];
      end
      if (m_bytesel[1]) begin
        word[15:8] = m_data_out[15:8];
      end
      mem[int'(m_addr)] = word;
      m_data_in = '0;
    end else begin
      m_data_in = word;
    end
  endtask

  // Memory side acknowledges after 0 to 5 cycles and drops it after one edge
  always @(negedge clk) begin
    if (reset) begin
      m_ack     = 1'b0;
      m_data_in = '0;
      in_beat   = 1'b0;
    end else if (m_ack) begin
      m_ack   = 1'b0;
      in_beat = 1'b0;
    end else if (m_access) begin
      if (!in_beat) begin
        in_beat  = 1'b1;
        wait_cnt = ack_delay[beat_idx % 64];
        beat_idx++;
      end
      if (wait_cnt == 0) begin
        serve_beat();
        m_ack = 1'b1;
      end else begin
        wait_cnt--;
      end
    end
  end

  // ==================================================
  // Microcode side
  // ==================================================
  // Loads MAR and MDR and holds the request until busy falls before checking
  task automatic run_access(input logic wr, input logic byte8, input logic [15:0] seg,
                            input logic [15:0] off, input logic [15:0] data);
    logic [19:0] ba;
    logic [19:0] ba_next;
    logic [18:0] w;
    logic [15:0] expected;
    int          first;
    ba      = {seg, 4'h0} + {4'h0, off};
    ba_next = ba + 20'd1;
    w       = ({3'b000, seg} << 3) + {4'h0, off[15:1]};
    // Read result taken from the reference before the access
    expected = byte8 ? {8'h00, byte_at(ba)} : {byte_at(ba_next), byte_at(ba)};
    if (wr) begin
      expected = data;
    end
    segment   = seg;
    mar_in    = off;
    mdr_in    = data;
    write_mar = 1'b1;
    write_mdr = wr;
    @(negedge clk);
    write_mar = 1'b0;
    write_mdr = 1'b0;
    first     = obs_addr_q.size();
    mem_write = wr;
    mem_read  = !wr;
    is_8bit   = byte8;
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    mem_write = 1'b0;
    mem_read  = 1'b0;
    is_8bit   = 1'b0;
    // Odd word goes high lane first and then to the low lane of the next word
    if (!byte8 && off[0]) begin
      if (beat_count_ok(first, 2)) begin
        check_beat(first, w, 2'b10, wr, {data[7:0], 8'h00});
        check_beat(first + 1, w + 19'd1, 2'b01, wr, {8'h00, data[15:8]});
      end
    end else if (beat_count_ok(first, 1)) begin
      if (!byte8) begin
        check_beat(first, w, 2'b11, wr, data);
      end else if (!off[0]) begin
        check_beat(first, w, 2'b01, wr, {8'h00, data[7:0]});
      end else begin
        check_beat(first, w, 2'b10, wr, {data[7:0], 8'h00});
      end
    end
    if (wr) begin
      ref_mem[int'(ba)] = data[7:0];
      if (!byte8) begin
        ref_mem[int'(ba_next)] = data[15:8];
      end
    end
    errors += check_value("mar_out", 32'(mar_out), 32'(off));
    errors += check_value("mdr_out", 32'(mdr_out), 32'(expected));
  endtask

  task automatic random_traffic(input int count);
    logic [15:0] seg;
    logic [15:0] off;
    logic [15:0] data;
    logic        wr;
    logic        byte8;
    int          i;
    // Small window so reads often land on earlier writes
    for (i = 0; i < count; i++) begin
      seg   = 16'h4000 + 16'($urandom_range(3, 0));
      off   = 16'($urandom_range(63, 0));
      data  = 16'($urandom);
      wr    = 1'($urandom_range(1, 0));
      byte8 = 1'($urandom_range(1, 0));
      run_access(wr, byte8, seg, off, data);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail with %0d errors", name, errors - errors_before);
    end
  endtask

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, an access never finished", cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    int unsigned seed_draw;
    int          errors_before;
    seed_draw = $urandom(SEED);
    foreach (ack_delay[k]) begin
      ack_delay[k] = $urandom_range(5, 0);
    end
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset        = 1'b1;
    write_mar    = 1'b0;
    segment      = '0;
    mar_in       = '0;
    write_mdr    = 1'b0;
    mdr_in       = '0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    is_8bit      = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    // Reset values
    errors_before = errors;
    @(negedge clk);
    errors += check_value("m_access", 32'(m_access), 32'h0);
    errors += check_value("m_wr_en", 32'(m_wr_en), 32'h0);
    errors += check_value("busy", 32'(busy), 32'h0);
    errors += check_value("m_addr", 32'(m_addr), 32'h0);
    errors += check_value("m_data_out", 32'(m_data_out), 32'h0);
    errors += check_value("m_bytesel", 32'(m_bytesel), 32'h0);
    errors += check_value("mdr_out", 32'(mdr_out), 32'h0);
    errors += check_value("mar_out", 32'(mar_out), 32'h0);
    report_test("reset", errors_before);

    errors_before = errors;
    run_access(1'b1, 1'b0, 16'h1234, 16'h0a2e, 16'hbeef);
    run_access(1'b0, 1'b0, 16'h1234, 16'h0a2e, 16'h0000);
    report_test("aligned word", errors_before);

    // High byte of the MDR must never reach memory on a byte write
    errors_before = errors;
    run_access(1'b1, 1'b1, 16'h0200, 16'h0040, 16'ha75a);
    run_access(1'b1, 1'b1, 16'h0200, 16'h0043, 16'h91c3);
    run_access(1'b0, 1'b0, 16'h0200, 16'h0042, 16'h0000);
    run_access(1'b0, 1'b1, 16'h0200, 16'h0040, 16'h0000);
    run_access(1'b0, 1'b1, 16'h0200, 16'h0043, 16'h0000);
    run_access(1'b0, 1'b1, 16'h0200, 16'h0041, 16'h0000);
    report_test("byte access", errors_before);

    errors_before = errors;
    run_access(1'b1, 1'b0, 16'h0fff, 16'h3331, 16'h1357);
    run_access(1'b0, 1'b0, 16'h0fff, 16'h3331, 16'h0000);
    run_access(1'b0, 1'b0, 16'h0fff, 16'h3335, 16'h0000);
    report_test("split word", errors_before);

    errors_before = errors;
    random_traffic(28);
    report_test("random traffic", errors_before);

    $display("%0d tests, %0d failed, %0d check errors, %0d protocol errors",
             tests_run, tests_failed, errors, dut0.props0.fail_count);
    if (errors == 0 && dut0.props0.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/lsu_state_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/lsu_sequencer.sv
verilog/lsu_address.sv
verilog/lsu_data.sv
verilog/lsu_top.sv
bench/lsu_props.sv
bench/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module lsu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/Vlsu_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
